/* dual_issue_testdata.txt */
# P slot0_word slot1_word order_bit  (order 1 means slot 1 is older)
# E older_word younger_word          (expected issue stream, program order)
P 04221800 04853000 0
E 04221800 04853000
P 80270000 04434000 0
E 80270000 04434000
P 04E24800 04855000 0
E 04E24800 04855000
P 04225800 05636000 0
E 04225800 05636000
P 05A17000 404D0000 1
E 404D0000 05A17000
P 84700000 80500000 1
E 80500000 84700000
P 88110000 C4310000 0
E 88110000 C4310000
P 00000000 8C120000 0
E 00000000 8C120000
P 402E7800 05E29800 0
E 402E7800 05E29800
P 04221800 04853000 1
E 04853000 04221800
P 80270000 04434000 0
E 80270000 04434000
P 04E24800 04855000 0
E 04E24800 04855000
P 05636000 04225800 1
E 04225800 05636000

/* src.f */
pipe_pkg.sv
instr_queue.sv
slot_decode.sv
hazard_detection_unit.sv
pipe_regs.sv
dual_issue_core.sv
tb_checker.sv
tb_dual_issue_sva.sv
tb_dual_issue.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dual_issue
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_dual_issue.sv */
`timescale 1ns/1ps

module tb_dual_issue;
  import pipe_pkg::*;

  localparam int QUEUE_DEPTH = 4;
  localparam int CLK_HALF    = 4;

  logic   clk;
  logic   rst_n;
  logic   pair_valid;
  instr_t pair_instr0;
  instr_t pair_instr1;
  logic   pair_first;
  logic   credit_return;
  logic   ex_valid0;
  logic   ex_valid1;
  instr_t ex_instr0;
  instr_t ex_instr1;
  logic   ex_first;

  instr_t pair0_q [$];
  instr_t pair1_q [$];
  logic   first_q [$];
  int     n_expected = 0;
  int     sent;
  int     returned;
  bit     loaded     = 1'b0;
  int     total_errs;

  dual_issue_core #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_dut (
    .clk(clk), .rst_n(rst_n),
    .pair_valid(pair_valid), .pair_instr0(pair_instr0), .pair_instr1(pair_instr1),
    .pair_first(pair_first), .credit_return(credit_return),
    .ex_valid0(ex_valid0), .ex_valid1(ex_valid1),
    .ex_instr0(ex_instr0), .ex_instr1(ex_instr1), .ex_first(ex_first)
  );

  tb_checker u_checker (
    .clk(clk), .rst_n(rst_n), .credit_return(credit_return),
    .ex_valid0(ex_valid0), .ex_valid1(ex_valid1),
    .ex_instr0(ex_instr0), .ex_instr1(ex_instr1), .ex_first(ex_first)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      returned <= 0;
    end else if (credit_return) begin
      returned <= returned + 1;
    end
  end

  // register written per the ISA table with bit 5 as its valid flag.
  function automatic logic [5:0] written_reg(input instr_t w);
    opcode_t    op;
    logic [5:0] dst;
    op  = opcode_t'(w[31:26]);
    dst = '0;
    if (op != OP_NOP && op[5:4] == 2'b00) begin
      dst = {1'b1, w[15:11]};
    end else if (op[5:4] == 2'b01 || op == OP_LW || op == OP_LA) begin
      dst = {1'b1, w[20:16]};
    end
    return dst;
  endfunction

  function automatic bit reads_reg(input instr_t w, input reg_idx_t r);
    opcode_t op;
    bit      rs_read;
    bit      rt_read;
    op      = opcode_t'(w[31:26]);
    rs_read = (op != OP_NOP && op[5:4] == 2'b00) || op[5:4] == 2'b01 ||
              op == OP_LW || op == OP_SW || op == OP_JR;
    rt_read = (op != OP_NOP && op[5:4] == 2'b00) || op == OP_SW || op == OP_SA;
    return (rs_read && w[25:21] == r) || (rt_read && w[20:16] == r);
  endfunction

  task automatic load_testdata(output bit ok);
    int         fd;
    int         code;
    string      line;
    instr_t     w0;
    instr_t     w1;
    int         f;
    logic [5:0] dst;
    ok = 1'b0;
    fd = $fopen("dual_issue_testdata.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (line.len() > 0 && line.substr(0, 0) == "P") begin
          code = $sscanf(line, "P %h %h %d", w0, w1, f);
          pair0_q.push_back(w0);
          pair1_q.push_back(w1);
          first_q.push_back(f[0]);
        end else if (line.len() > 0 && line.substr(0, 0) == "E") begin
          code = $sscanf(line, "E %h %h", w0, w1);
          dst  = written_reg(w0);
          u_checker.add_expected(w0, 1'b0);
          // younger shares the cycle unless it reads what the older writes.
          u_checker.add_expected(w1, !(dst[5] && reads_reg(w1, dst[4:0])));
          n_expected += 2;
        end
      end
      $fclose(fd);
      ok = 1'b1;
    end
  endtask

  initial begin
    bit ok;
    load_testdata(ok);
    if (ok) begin
      loaded = 1'b1;
    end else begin
      $display("Could not open dual_issue_testdata.txt");
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    wait (loaded);
    repeat (20 * pair0_q.size() + 100) @(posedge clk);
    $display("Timeout: the expected issue stream did not complete in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int gap;
    int i;
    pair_valid  = 1'b0;
    pair_instr0 = '0;
    pair_instr1 = '0;
    pair_first  = 1'b0;
    rst_n       = 1'b0;
    sent        = 0;
    void'($urandom(82594));
    wait (loaded);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    i   = 0;
    gap = $urandom % 3;
    while (i < pair0_q.size()) begin
      @(negedge clk);
      if (gap > 0 || (sent - returned) >= QUEUE_DEPTH) begin  // idle or out of credit.
        pair_valid = 1'b0;
        if (gap > 0) gap--;
      end else begin
        pair_valid  = 1'b1;
        pair_instr0 = pair0_q[i];
        pair_instr1 = pair1_q[i];
        pair_first  = first_q[i];
        sent++;
        i++;
        gap = $urandom % 3;
      end
    end
    @(negedge clk);
    pair_valid = 1'b0;
    while (u_checker.n_checked < n_expected) @(posedge clk);
    repeat (10) @(posedge clk);  // room for stray issues and late credits.
    u_checker.final_check(sent);
    total_errs = u_checker.mismatch_errs + u_checker.missing_errs +
                 u_checker.extra_errs + u_checker.group_errs + u_checker.credit_errs;
    $display("errors: mismatch=%0d missing=%0d extra=%0d group=%0d credit=%0d total=%0d",
             u_checker.mismatch_errs, u_checker.missing_errs, u_checker.extra_errs,
             u_checker.group_errs, u_checker.credit_errs, total_errs);
    if (total_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* tb_dual_issue_sva.sv */
`timescale 1ns/1ps

module tb_dual_issue_sva #(
  parameter int QUEUE_DEPTH = 4
) (
  input logic                clk,
  input logic                rst_n,
  input logic                pair_valid,
  input logic                credit_return,
  input logic                ex_valid0,
  input logic                ex_valid1,
  input pipe_pkg::mem_op_t   id_ex_mem_op,
  input pipe_pkg::reg_idx_t  id_ex_rt,
  input pipe_pkg::reg_idx_t  rs0,
  input pipe_pkg::reg_idx_t  rt0,
  input pipe_pkg::reg_idx_t  rs1,
  input pipe_pkg::reg_idx_t  rt1,
  input pipe_pkg::use_mask_t src_mask0,
  input pipe_pkg::use_mask_t src_mask1,
  input pipe_pkg::instr_t    if_id_instr0,
  input pipe_pkg::instr_t    if_id_instr1
);
  import pipe_pkg::*;

  int   outstanding;
  logic reads0;
  logic reads1;
  logic load_use;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(pair_valid) - int'(credit_return);
    end
  end

  assign reads0   = ((src_mask0 & USE_RS) != 0 && rs0 == id_ex_rt) ||
                    ((src_mask0 & USE_RT) != 0 && rt0 == id_ex_rt);
  assign reads1   = ((src_mask1 & USE_RS) != 0 && rs1 == id_ex_rt) ||
                    ((src_mask1 & USE_RT) != 0 && rt1 == id_ex_rt);
  assign load_use = (id_ex_mem_op == MEM_OP_READ) && (reads0 || reads1);

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !credit_return && !ex_valid0 && !ex_valid1)
    else $error("credit_return or ex_valid high in reset");

  a_credit_held: assert property (@(posedge clk) disable iff (!rst_n)
    pair_valid |-> outstanding < QUEUE_DEPTH)
    else $error("pair sent without a credit");

  // empty issue slots while the pair waits in IF/ID.
  a_load_use_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    load_use |=> !ex_valid0 && !ex_valid1 &&
                 $stable(if_id_instr0) && $stable(if_id_instr1))
    else $error("no bubble after load-use");

endmodule

bind dual_issue_core tb_dual_issue_sva #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_sva (
  .clk(clk), .rst_n(rst_n), .pair_valid(pair_valid), .credit_return(credit_return),
  .ex_valid0(ex_valid0), .ex_valid1(ex_valid1),
  .id_ex_mem_op(id_ex_mem_op), .id_ex_rt(id_ex_rt),
  .rs0(rs0), .rt0(rt0), .rs1(rs1), .rt1(rt1),
  .src_mask0(src_mask0), .src_mask1(src_mask1),
  .if_id_instr0(if_id_instr0), .if_id_instr1(if_id_instr1)
);

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
  input logic             clk,
  input logic             rst_n,
  input logic             credit_return,
  input logic             ex_valid0,
  input logic             ex_valid1,
  input pipe_pkg::instr_t ex_instr0,
  input pipe_pkg::instr_t ex_instr1,
  input logic             ex_first
);
  import pipe_pkg::*;

  instr_t exp_q [$];
  bit     with_q [$];
  int     n_checked     = 0;
  int     credits_seen  = 0;
  int     mismatch_errs = 0;
  int     missing_errs  = 0;
  int     extra_errs    = 0;
  int     group_errs    = 0;
  int     credit_errs   = 0;

  task automatic add_expected(input instr_t w, input bit with_older);
    exp_q.push_back(w);
    with_q.push_back(with_older);
  endtask

  task automatic check_issue(input instr_t got, input bit paired);
    instr_t exp;
    bit     exp_paired;
    if (exp_q.size() == 0) begin
      $display("Extra issue: instruction %08h arrived after the expected stream ended", got);
      extra_errs++;
    end else begin
      exp        = exp_q.pop_front();
      exp_paired = with_q.pop_front();
      if (got !== exp) begin
        $display("[FAIL] ex_instr expected %08h got %08h", exp, got);
        mismatch_errs++;
      end
      if (paired && !exp_paired) begin
        $display("Grouping wrong: %08h issued with its older partner, not alone", got);
        group_errs++;
      end else if (!paired && exp_paired) begin
        $display("Grouping wrong: %08h issued alone, not with its older partner", got);
        group_errs++;
      end
      n_checked++;
    end
  endtask

  // older slot first, per the order bit.
  always @(negedge clk) begin
    if (rst_n) begin
      if (credit_return) credits_seen++;
      if (ex_first) begin
        if (ex_valid1) check_issue(ex_instr1, 1'b0);
        if (ex_valid0) check_issue(ex_instr0, ex_valid1);
      end else begin
        if (ex_valid0) check_issue(ex_instr0, 1'b0);
        if (ex_valid1) check_issue(ex_instr1, ex_valid0);
      end
    end
  end

  task automatic final_check(input int pairs_sent);
    if (exp_q.size() != 0) begin
      $display("Missing issue: %0d expected instructions never issued", exp_q.size());
      missing_errs += exp_q.size();
    end
    if (credits_seen != pairs_sent) begin
      $display("Credit count wrong: %0d returned for %0d pairs sent", credits_seen, pairs_sent);
      credit_errs++;
    end
  endtask

endmodule

/* dual_issue_core.sv */
`timescale 1ns/1ps

module dual_issue_core #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             pair_valid,
  input  pipe_pkg::instr_t pair_instr0,
  input  pipe_pkg::instr_t pair_instr1,
  input  logic             pair_first,
  output logic             credit_return,
  output logic             ex_valid0,
  output logic             ex_valid1,
  output pipe_pkg::instr_t ex_instr0,
  output pipe_pkg::instr_t ex_instr1,
  output logic             ex_first
);
  import pipe_pkg::*;

  logic       q_valid;
  instr_t     q_instr0;
  instr_t     q_instr1;
  logic       q_first;
  logic       stall_pc;
  instr_t     if_id_instr0;
  instr_t     if_id_instr1;
  logic       if_id_first;
  opcode_t    opcode0;
  opcode_t    opcode1;
  reg_idx_t   rs0;
  reg_idx_t   rt0;
  reg_idx_t   rd0;
  reg_idx_t   rs1;
  reg_idx_t   rt1;
  reg_idx_t   rd1;
  use_mask_t  src_mask0;
  use_mask_t  dst_mask0;
  use_mask_t  src_mask1;
  use_mask_t  dst_mask1;
  mem_op_t    mem_op0;
  mem_op_t    mem_op1;
  mem_op_t    id_ex_mem_op;
  reg_idx_t   id_ex_rt;
  pipe_mask_t stall0;
  pipe_mask_t nop0;
  pipe_mask_t stall1;
  pipe_mask_t nop1;

  instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clk(clk), .rst_n(rst_n),
    .pair_valid(pair_valid), .pair_instr0(pair_instr0), .pair_instr1(pair_instr1),
    .pair_first(pair_first), .stall_pc(stall_pc),
    .q_valid(q_valid), .q_instr0(q_instr0), .q_instr1(q_instr1), .q_first(q_first),
    .credit_return(credit_return)
  );

  slot_decode u_dec0 (
    .instr(if_id_instr0), .opcode(opcode0), .rs(rs0), .rt(rt0), .rd(rd0),
    .src_mask(src_mask0), .dst_mask(dst_mask0), .mem_op(mem_op0)
  );

  slot_decode u_dec1 (
    .instr(if_id_instr1), .opcode(opcode1), .rs(rs1), .rt(rt1), .rd(rd1),
    .src_mask(src_mask1), .dst_mask(dst_mask1), .mem_op(mem_op1)
  );

  hazard_detection_unit u_hazard (
    .id_ex_mem_op(id_ex_mem_op), .id_ex_rt(id_ex_rt), .first(if_id_first),
    .if_id_opcode0(opcode0), .if_id_rs0(rs0), .if_id_rt0(rt0), .if_id_rd0(rd0),
    .src_mask0(src_mask0), .dst_mask0(dst_mask0),
    .if_id_opcode1(opcode1), .if_id_rs1(rs1), .if_id_rt1(rt1), .if_id_rd1(rd1),
    .src_mask1(src_mask1), .dst_mask1(dst_mask1),
    .stall0(stall0), .nop0(nop0), .stall1(stall1), .nop1(nop1)
  );

  pipe_regs u_regs (
    .clk(clk), .rst_n(rst_n),
    .q_valid(q_valid), .q_instr0(q_instr0), .q_instr1(q_instr1), .q_first(q_first),
    .stall0(stall0), .nop0(nop0), .stall1(stall1), .nop1(nop1),
    .mem_op0(mem_op0), .rt0(rt0), .mem_op1(mem_op1), .rt1(rt1),
    .stall_pc(stall_pc),
    .if_id_instr0(if_id_instr0), .if_id_instr1(if_id_instr1), .if_id_first(if_id_first),
    .id_ex_mem_op(id_ex_mem_op), .id_ex_rt(id_ex_rt),
    .ex_valid0(ex_valid0), .ex_valid1(ex_valid1),
    .ex_instr0(ex_instr0), .ex_instr1(ex_instr1), .ex_first(ex_first)
  );

endmodule

/* pipe_regs.sv */
`timescale 1ns/1ps

module pipe_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 q_valid,
  input  pipe_pkg::instr_t     q_instr0,
  input  pipe_pkg::instr_t     q_instr1,
  input  logic                 q_first,
  input  pipe_pkg::pipe_mask_t stall0,
  input  pipe_pkg::pipe_mask_t nop0,
  input  pipe_pkg::pipe_mask_t stall1,
  input  pipe_pkg::pipe_mask_t nop1,
  input  pipe_pkg::mem_op_t    mem_op0,
  input  pipe_pkg::reg_idx_t   rt0,
  input  pipe_pkg::mem_op_t    mem_op1,
  input  pipe_pkg::reg_idx_t   rt1,
  output logic                 stall_pc,
  output pipe_pkg::instr_t     if_id_instr0,
  output pipe_pkg::instr_t     if_id_instr1,
  output logic                 if_id_first,
  output pipe_pkg::mem_op_t    id_ex_mem_op,
  output pipe_pkg::reg_idx_t   id_ex_rt,
  output logic                 ex_valid0,
  output logic                 ex_valid1,
  output pipe_pkg::instr_t     ex_instr0,
  output pipe_pkg::instr_t     ex_instr1,
  output logic                 ex_first
);
  import pipe_pkg::*;

  pipe_mask_t stall      [2];
  pipe_mask_t nop        [2];
  instr_t     q_instr    [2];
  mem_op_t    dec_mem_op [2];
  reg_idx_t   dec_rt     [2];
  logic       pop;
  logic       load1;

  assign stall[0]      = stall0;
  assign stall[1]      = stall1;
  assign nop[0]        = nop0;
  assign nop[1]        = nop1;
  assign q_instr[0]    = q_instr0;
  assign q_instr[1]    = q_instr1;
  assign dec_mem_op[0] = mem_op0;
  assign dec_mem_op[1] = mem_op1;
  assign dec_rt[0]     = rt0;
  assign dec_rt[1]     = rt1;

  assign stall_pc = |((stall0 | stall1) & PIPE_PC);
  assign pop      = q_valid && !stall_pc;

  for (genvar k = 0; k < 2; k++) begin : g_slot
    logic     hold_if_id;
    logic     kill_if_id;
    logic     hold_id_ex;
    logic     kill_id_ex;
    logic     if_id_valid;
    instr_t   if_id_instr;
    instr_t   if_id_word;
    logic     ex_valid;
    instr_t   ex_instr;
    mem_op_t  ex_mem_op;
    reg_idx_t ex_rt;

    assign hold_if_id = |(stall[k] & PIPE_IF_ID);
    assign kill_if_id = |(nop[k] & PIPE_IF_ID);
    assign hold_id_ex = |(stall[k] & PIPE_ID_EX);
    assign kill_id_ex = |(nop[k] & PIPE_ID_EX);
    assign if_id_word = if_id_valid ? if_id_instr : '0;  // empty slot reads as nop.

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        if_id_valid <= 1'b0;
      end else if (kill_if_id) begin
        if_id_valid <= 1'b0;
      end else if (!hold_if_id) begin
        if_id_valid <= pop;
      end
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        ex_valid  <= 1'b0;
        ex_mem_op <= MEM_OP_NONE;
      end else if (kill_id_ex) begin  // bubble.
        ex_valid  <= 1'b0;
        ex_mem_op <= MEM_OP_NONE;
      end else if (!hold_id_ex) begin
        ex_valid  <= if_id_valid;
        ex_mem_op <= dec_mem_op[k];
      end
    end

    always_ff @(posedge clk) begin
      if (!hold_if_id && pop) begin
        if_id_instr <= q_instr[k];
      end
      if (!kill_id_ex && !hold_id_ex) begin
        ex_instr <= if_id_word;
        ex_rt    <= dec_rt[k];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_first <= 1'b0;
      ex_first    <= 1'b0;
    end else begin
      if (pop) begin
        if_id_first <= q_first;
      end
      ex_first <= if_id_first;  // a split pair keeps its order bit.
    end
  end

  assign if_id_instr0 = g_slot[0].if_id_word;
  assign if_id_instr1 = g_slot[1].if_id_word;
  assign ex_valid0    = g_slot[0].ex_valid;
  assign ex_valid1    = g_slot[1].ex_valid;
  assign ex_instr0    = g_slot[0].ex_instr;
  assign ex_instr1    = g_slot[1].ex_instr;

  // load slot for the load-use check.
  assign load1        = (g_slot[1].ex_mem_op == MEM_OP_READ);
  assign id_ex_mem_op = load1 ? g_slot[1].ex_mem_op : g_slot[0].ex_mem_op;
  assign id_ex_rt     = load1 ? g_slot[1].ex_rt : g_slot[0].ex_rt;

endmodule

/* hazard_detection_unit.sv */
`timescale 1ns/1ps

module hazard_detection_unit (
  input  pipe_pkg::mem_op_t    id_ex_mem_op,
  input  pipe_pkg::reg_idx_t   id_ex_rt,
  input  logic                 first,
  input  pipe_pkg::opcode_t    if_id_opcode0,
  input  pipe_pkg::reg_idx_t   if_id_rs0,
  input  pipe_pkg::reg_idx_t   if_id_rt0,
  input  pipe_pkg::reg_idx_t   if_id_rd0,
  input  pipe_pkg::use_mask_t  src_mask0,
  input  pipe_pkg::use_mask_t  dst_mask0,
  input  pipe_pkg::opcode_t    if_id_opcode1,
  input  pipe_pkg::reg_idx_t   if_id_rs1,
  input  pipe_pkg::reg_idx_t   if_id_rt1,
  input  pipe_pkg::reg_idx_t   if_id_rd1,
  input  pipe_pkg::use_mask_t  src_mask1,
  input  pipe_pkg::use_mask_t  dst_mask1,
  output pipe_pkg::pipe_mask_t stall0,
  output pipe_pkg::pipe_mask_t nop0,
  output pipe_pkg::pipe_mask_t stall1,
  output pipe_pkg::pipe_mask_t nop1
);
  import pipe_pkg::*;

  localparam pipe_mask_t STALL_ALL   = PIPE_PC | PIPE_IF_ID | PIPE_ID_EX;
  localparam pipe_mask_t STALL_FRONT = PIPE_PC | PIPE_IF_ID;

  logic live0;
  logic live1;
  logic load_use;
  logic pair_dep;

  // y reads what o writes, checked only through fields the masks enable.
  function automatic logic dep_match(
    input use_mask_t y_src,
    input reg_idx_t  y_rs,
    input reg_idx_t  y_rt,
    input use_mask_t o_dst,
    input reg_idx_t  o_rt,
    input reg_idx_t  o_rd
  );
    logic rs_use;
    logic rt_use;
    logic rt_def;
    logic rd_def;
    rs_use = |(y_src & USE_RS);
    rt_use = |(y_src & USE_RT);
    rt_def = |(o_dst & USE_RT);
    rd_def = |(o_dst & USE_RD);
    return (rs_use && rt_def && (y_rs == o_rt)) ||
           (rs_use && rd_def && (y_rs == o_rd)) ||
           (rt_use && rt_def && (y_rt == o_rt)) ||
           (rt_use && rd_def && (y_rt == o_rd));
  endfunction

  assign live0 = (if_id_opcode0 != OP_NOP);
  assign live1 = (if_id_opcode1 != OP_NOP);

  // load in ID/EX seen as an rt-writer.
  assign load_use = (id_ex_mem_op == MEM_OP_READ) &&
                    ((live0 && dep_match(src_mask0, if_id_rs0, if_id_rt0,
                                         USE_RT, id_ex_rt, id_ex_rt)) ||
                     (live1 && dep_match(src_mask1, if_id_rs1, if_id_rt1,
                                         USE_RT, id_ex_rt, id_ex_rt)));

  assign pair_dep = live0 && live1 &&
                    (first ? dep_match(src_mask0, if_id_rs0, if_id_rt0,
                                       dst_mask1, if_id_rt1, if_id_rd1)
                           : dep_match(src_mask1, if_id_rs1, if_id_rt1,
                                       dst_mask0, if_id_rt0, if_id_rd0));

  always_comb begin
    stall0 = '0;
    nop0   = '0;
    stall1 = '0;
    nop1   = '0;
    if (load_use) begin  // one bubble, pair held.
      stall0 = STALL_ALL;
      nop0   = PIPE_ID_EX;
      stall1 = STALL_ALL;
      nop1   = PIPE_ID_EX;
    end else if (pair_dep) begin
      if (first) begin  // slot 1 older.
        stall0 = STALL_ALL;
        nop0   = PIPE_ID_EX;
        stall1 = STALL_FRONT;
        nop1   = PIPE_IF_ID;
      end else begin
        stall1 = STALL_ALL;
        nop1   = PIPE_ID_EX;
        stall0 = STALL_FRONT;
        nop0   = PIPE_IF_ID;
      end
    end
  end

endmodule

/* slot_decode.sv */
`timescale 1ns/1ps

module slot_decode (
  input  pipe_pkg::instr_t    instr,
  output pipe_pkg::opcode_t   opcode,
  output pipe_pkg::reg_idx_t  rs,
  output pipe_pkg::reg_idx_t  rt,
  output pipe_pkg::reg_idx_t  rd,
  output pipe_pkg::use_mask_t src_mask,
  output pipe_pkg::use_mask_t dst_mask,
  output pipe_pkg::mem_op_t   mem_op
);
  import pipe_pkg::*;

  assign opcode = opcode_t'(instr[31:26]);
  assign rs     = reg_idx_t'(instr[25:21]);
  assign rt     = reg_idx_t'(instr[20:16]);
  assign rd     = reg_idx_t'(instr[15:11]);

  always_comb begin
    src_mask = USE_NONE;
    dst_mask = USE_NONE;
    mem_op   = MEM_OP_NONE;
    if (opcode == OP_JR) begin
      src_mask = USE_RS;
    end else if (opcode != OP_NOP) begin
      case (opcode[5:4])
        2'b00: begin  // add, sub and friends.
          src_mask = USE_RS | USE_RT;
          dst_mask = USE_RD;
        end
        2'b01: begin
          src_mask = USE_RS;
          dst_mask = USE_RT;
        end
        2'b10: begin
          case (opcode)
            OP_LW: begin
              src_mask = USE_RS;
              dst_mask = USE_RT;
              mem_op   = MEM_OP_READ;
            end
            OP_SW: begin
              src_mask = USE_RS | USE_RT;
              mem_op   = MEM_OP_WRITE;
            end
            OP_LA: begin  // absolute address, no base reg.
              dst_mask = USE_RT;
              mem_op   = MEM_OP_READ;
            end
            OP_SA: begin
              src_mask = USE_RT;
              mem_op   = MEM_OP_WRITE;
            end
            default: mem_op = MEM_OP_NONE;
          endcase
        end
        default: src_mask = USE_NONE;  // jumps.
      endcase
    end
  end

endmodule

/* instr_queue.sv */
`timescale 1ns/1ps

module instr_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             pair_valid,
  input  pipe_pkg::instr_t pair_instr0,
  input  pipe_pkg::instr_t pair_instr1,
  input  logic             pair_first,
  input  logic             stall_pc,
  output logic             q_valid,
  output pipe_pkg::instr_t q_instr0,
  output pipe_pkg::instr_t q_instr1,
  output logic             q_first,
  output logic             credit_return
);
  import pipe_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  instr_t           mem0      [QUEUE_DEPTH];
  instr_t           mem1      [QUEUE_DEPTH];
  logic             first_mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign q_valid  = (count != '0);
  assign pop      = q_valid && !stall_pc;
  assign q_instr0 = mem0[rd_ptr];
  assign q_instr1 = mem1[rd_ptr];
  assign q_first  = first_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (pair_valid) begin  // credits rule out a full queue.
      mem0[wr_ptr]      <= pair_instr0;
      mem1[wr_ptr]      <= pair_instr1;
      first_mem[wr_ptr] <= pair_first;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop;  // one credit per pop, a cycle later.
      if (pair_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({pair_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* pipe_pkg.sv */
package pipe_pkg;

  localparam int REG_IDX_BITS = 5;

  typedef logic [31:0]             instr_t;  // op, rs, rt, rd, imm11.
  typedef logic [5:0]              opcode_t;
  typedef logic [REG_IDX_BITS-1:0] reg_idx_t;
  typedef logic [2:0]              use_mask_t;  // rs, rt, rd.
  typedef logic [2:0]              pipe_mask_t;
  typedef logic [1:0]              mem_op_t;

  // 00xxxx alu reg, 01xxxx alu imm, 10xxxx memory, 11xxxx jumps.
  localparam opcode_t OP_NOP = 6'b000000;
  localparam opcode_t OP_LW  = 6'b100000;
  localparam opcode_t OP_SW  = 6'b100001;
  localparam opcode_t OP_LA  = 6'b100010;
  localparam opcode_t OP_SA  = 6'b100011;
  localparam opcode_t OP_JR  = 6'b110000;  // only jump that reads a register.

  localparam use_mask_t USE_NONE = 3'b000;
  localparam use_mask_t USE_RS   = 3'b100;
  localparam use_mask_t USE_RT   = 3'b010;
  localparam use_mask_t USE_RD   = 3'b001;

  localparam pipe_mask_t PIPE_PC    = 3'b001;
  localparam pipe_mask_t PIPE_IF_ID = 3'b010;
  localparam pipe_mask_t PIPE_ID_EX = 3'b100;

  localparam mem_op_t MEM_OP_NONE  = 2'd0;
  localparam mem_op_t MEM_OP_READ  = 2'd1;
  localparam mem_op_t MEM_OP_WRITE = 2'd2;

endpackage
